/* audio_mixer.f */
+incdir+include
src/audio_pkg.sv
src/audio_pdm_dac.sv
src/audio_channel.sv
src/audio_fetch_arb.sv
src/audio_mix.sv
src/audio_subsys_top.sv
bench/audio_tb_clk.sv
bench/audio_tb.sv

/* bench/audio_tb.sv */
// testbench for the sample audio subsystem
// channel k plays from 16'hk020 so a request address tells its channel
// addresses 16'hFxxx return a constant word 16'h4040 for the duty tests

`timescale 1ns/100ps

`include "audio_config.svh"

module audio_tb;

import audio_pkg::*;

localparam int NCHAN = `AUDIO_NCHAN;
localparam int NROWS = 6;

logic                       clk;
logic                       reset_i;
logic                       chan_enable[NCHAN];
vol_t                       chan_vol[NCHAN];
logic [`AUDIO_PERIOD_W-1:0] chan_period[NCHAN];
addr_t                      chan_start[NCHAN];
logic [`AUDIO_LEN_W-1:0]    chan_len[NCHAN];
logic                       chan_restart[NCHAN];
logic                       reload[NCHAN];
logic                       irq;
logic                       mem_req_valid;
logic                       mem_req_ready;
addr_t                      mem_addr;
logic                       mem_rsp_valid;
word_t                      mem_rsp_data;
logic                       pdm_l;
logic                       pdm_r;

// stimulus table, one row per test
logic [3:0] row_en[NROWS];          // enabled channel mask
int         row_period[NROWS];
int         row_len[NROWS];
logic       row_bp[NROWS];          // random back-pressure
logic       row_duty[NROWS];        // constant sample, measure PDM duty
int         row_cycles[NROWS];

int         errors;
int         checks;
int         limit;
logic       bp_on;
logic       force_ready;
logic       seq_on;
logic [3:0] cur_en;
int         cur_len;
int         exp_next[NCHAN];
int         first_seen[NCHAN];
int         reload_seen[NCHAN];
int         last_addr;
int         acc_count;
int         irq_exp;
int         wait_cnt;
word_t      rsp_word;

audio_tb_clk i_clk (.clk_o(clk));

audio_subsys_top i_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .chan_enable_i  (chan_enable),
    .chan_vol_i     (chan_vol),
    .chan_period_i  (chan_period),
    .chan_start_i   (chan_start),
    .chan_len_i     (chan_len),
    .chan_restart_i (chan_restart),
    .reload_o       (reload),
    .irq_o          (irq),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_ready_i(mem_req_ready),
    .mem_addr_o     (mem_addr),
    .mem_rsp_valid_i(mem_rsp_valid),
    .mem_rsp_data_i (mem_rsp_data),
    .pdm_l_o        (pdm_l),
    .pdm_r_o        (pdm_r)
);

task automatic check_val(input string name, input int got, input int exp, input int tol);
    checks++;
    if (got > exp + tol || got < exp - tol) begin
        errors++;
        $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

function automatic int start_of(input int k);
    return k * 4096 + 32;
endfunction

// expected unsigned mixer value for nplay channels of one sample at one gain
function automatic int mix_expect(input int nplay, input int smp, input int gain);
    int sum;
    sum = (nplay * smp * gain) >>> 7;
    if (sum > 127) begin
        sum = 127;
    end else if (sum < -128) begin
        sum = -128;
    end
    return sum + 128;
endfunction

function automatic word_t mem_word(input addr_t a);
    if (a[15:12] == 4'hf) begin
        return 16'h4040;
    end
    return {a[7:0], ~a[7:0]};
endfunction

task automatic count_pdm(output int cnt_l, output int cnt_r);
    cnt_l = 0;
    cnt_r = 0;
    repeat (256) begin
        @(posedge clk);
        if (pdm_l) cnt_l++;
        if (pdm_r) cnt_r++;
    end
endtask

// memory model with random ready and 1..4 cycle response delay
always @(posedge clk) begin
    if (reset_i) begin
        mem_req_ready <= 1'b0;
        mem_rsp_valid <= 1'b0;
        wait_cnt = 0;
    end else begin
        mem_rsp_valid <= 1'b0;
        if (mem_req_valid && mem_req_ready) begin
            rsp_word = mem_word(mem_addr);
            wait_cnt = 1 + int'($urandom % 4);
        end else if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= rsp_word;
            end
        end
        mem_req_ready <= (bp_on && !force_ready) ? (($urandom % 3) != 0) : 1'b1;
    end
end

// request address, reload and irq monitor
always @(posedge clk) begin
    int c;
    if (!reset_i) begin
        check_val("irq_o", int'(irq), irq_exp, 0);
        irq_exp = 0;
        for (int k = 0; k < NCHAN; k++) begin
            if (reload[k]) begin
                reload_seen[k] = 1;
                irq_exp = 1;
            end
        end
        if (mem_req_valid && mem_req_ready && seq_on) begin
            c = int'(mem_addr[15:12]);
            last_addr = int'(mem_addr);
            acc_count++;
            if (c >= NCHAN || !cur_en[c]) begin
                errors++;
                $display("request at %0t for address %h of a disabled channel", $time, mem_addr);
            end else begin
                check_val("mem_addr_o", int'(mem_addr), exp_next[c], 0);
                if (int'(mem_addr) == start_of(c) && first_seen[c] != 0) begin
                    check_val("reload_o", reload_seen[c], 1, 0);
                    reload_seen[c] = 0;
                end
                first_seen[c] = 1;
                exp_next[c] = (exp_next[c] == start_of(c) + cur_len) ? start_of(c)
                                                                      : exp_next[c] + 1;
            end
        end
    end
end

task automatic apply_row(input int r);
    int cnt_l;
    int cnt_r;
    int nplay;
    nplay = 0;
    cur_en  = row_en[r];
    cur_len = row_len[r];
    for (int k = 0; k < NCHAN; k++) begin
        exp_next[k]    = start_of(k);
        first_seen[k]  = 0;
        reload_seen[k] = 0;
        if (row_en[r][k]) nplay++;
    end
    bp_on       = row_bp[r];
    force_ready = 1'b0;
    seq_on      = !row_duty[r];
    @(posedge clk);
    // a parked channel picks up start and length before it is enabled
    for (int k = 0; k < NCHAN; k++) begin
        chan_period[k] <= `AUDIO_PERIOD_W'(row_period[r]);
        chan_len[k]    <= `AUDIO_LEN_W'(row_len[r]);
        chan_start[k]  <= row_duty[r] ? addr_t'(32'hf000 + k * 16) : addr_t'(start_of(k));
        chan_vol[k]    <= row_duty[r] ? 16'hfe00 : 16'h8080;     // full left, silent right
    end
    @(posedge clk);
    for (int k = 0; k < NCHAN; k++) begin
        chan_enable[k] <= row_en[r][k];
    end
    repeat (row_cycles[r] - 256) @(posedge clk);
    count_pdm(cnt_l, cnt_r);
    if (row_duty[r]) begin
        check_val("pdm_l_o duty", cnt_l, mix_expect(nplay, 64, 127), 2);
        check_val("pdm_r_o duty", cnt_r, 128, 2);
    end
    // drain any fetch in flight before the next row
    seq_on      = 1'b0;
    force_ready = 1'b1;
    for (int k = 0; k < NCHAN; k++) begin
        chan_enable[k] <= 1'b0;
    end
    repeat (30) @(posedge clk);
endtask

initial begin
    int cnt_l;
    int cnt_r;
    int seen;
    void'($urandom(32'h9079));
    errors = 0;
    checks = 0;
    acc_count = 0;
    last_addr = -1;
    irq_exp = 0;
    bp_on = 1'b0;
    force_ready = 1'b0;
    seq_on = 1'b0;
    cur_en = '0;
    cur_len = 0;
    reset_i = 1'b1;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data = '0;
    for (int k = 0; k < NCHAN; k++) begin
        chan_enable[k]  = 1'b0;
        chan_vol[k]     = '0;
        chan_period[k]  = '0;
        chan_start[k]   = '0;
        chan_len[k]     = '0;
        chan_restart[k] = 1'b0;
    end
    row_en = '{4'b0001, 4'b1011, 4'b1111, 4'b0110, 4'b0001, 4'b0011};
    row_period = '{3, 5, 7, 2, 9, 9};
    row_len    = '{5, 3, 4, 6, 3, 3};
    row_bp     = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    row_duty   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    row_cycles = '{600, 800, 1500, 1000, 700, 700};
    limit = 3000;
    for (int r = 0; r < NROWS; r++) begin
        limit += row_cycles[r] + 40;
    end

    repeat (8) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    check_val("mem_req_valid_o", int'(mem_req_valid), 0, 0);
    check_val("irq_o", int'(irq), 0, 0);
    for (int k = 0; k < NCHAN; k++) begin
        check_val("reload_o", int'(reload[k]), 0, 0);
    end
    count_pdm(cnt_l, cnt_r);
    check_val("pdm_l_o idle duty", cnt_l, 128, 1);
    check_val("pdm_r_o idle duty", cnt_r, 128, 1);

    for (int r = 0; r < NROWS; r++) begin
        apply_row(r);
    end

    // restart of a playing channel goes back to its start address
    cur_en = 4'b0001;
    cur_len = 7;
    exp_next[0] = start_of(0);
    first_seen[0] = 0;
    reload_seen[0] = 0;
    bp_on = 1'b0;
    force_ready = 1'b0;
    seq_on = 1'b1;
    chan_period[0] <= 15'd40;
    chan_len[0]    <= 15'd7;
    chan_start[0]  <= addr_t'(start_of(0));
    @(posedge clk);
    chan_enable[0] <= 1'b1;
    while (last_addr != start_of(0) + 2) @(posedge clk);
    repeat (15) @(posedge clk);
    chan_restart[0] <= 1'b1;
    @(posedge clk);
    chan_restart[0] <= 1'b0;
    exp_next[0] = start_of(0);
    seen = acc_count;
    while (acc_count == seen) @(posedge clk);
    check_val("restart mem_addr_o", last_addr, start_of(0), 0);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

// watchdog sized from the table
initial begin
    #1;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
end

endmodule

/* bench/audio_tb_clk.sv */
// free running testbench clock, 20 ns period by default

`timescale 1ns/100ps

module audio_tb_clk #(
    parameter int HALF_NS = 10
) (
    output logic clk_o
);

initial begin
    clk_o = 1'b0;
end

always #(HALF_NS) clk_o = ~clk_o;   // toggles forever, the run ends by $finish

endmodule

/* include/audio_config.svh */
// build-time sizing for the sample audio subsystem
// channel count is fixed here; the RTL has no other way to change it
// widths must stay consistent with the sample memory and channel controls

`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// number of sample channels
`define AUDIO_NCHAN     4

// sample memory word address width (one address space, 16-bit words)
`define AUDIO_ADDR_W    16

// playback period counter width, one sample every period+1 clocks
`define AUDIO_PERIOD_W  15

// sample length in words, a length of L plays L+1 words
`define AUDIO_LEN_W     15

`endif

/* run_sim.sh */
#!/bin/bash
# builds the audio subsystem testbench with Verilator and runs it
# exit status is 0 only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module audio_tb -f audio_mixer.f -o audio_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/audio_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

/* src/audio_channel.sv */
// one sample channel: period timer, word address walker and word buffer
// a late fill replays the old buffer, the address only moves after a fill
// a restart while a fetch is in flight drops that fetch's data and refetches

`default_nettype none
`timescale 1ns/100ps

`include "audio_config.svh"

module audio_channel (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       enable_i,
    input  wire audio_pkg::vol_t            vol_i,
    input  wire logic [`AUDIO_PERIOD_W-1:0] period_i,
    input  wire audio_pkg::addr_t           start_i,
    input  wire logic [`AUDIO_LEN_W-1:0]    len_i,
    input  wire logic                       restart_i,
    output      logic                       fetch_req_o,
    output      audio_pkg::addr_t           fetch_addr_o,
    input  wire logic                       fill_i,
    input  wire audio_pkg::word_t           fill_data_i,
    output      audio_pkg::sample_t         sample_o,
    output      logic                       reload_o
);

import audio_pkg::*;

logic [`AUDIO_PERIOD_W-1:0] period_cnt;     // clocks until next sample
logic                       second_half;    // next advance plays the low byte
addr_t                      cur_addr;       // word being fetched or played
logic [`AUDIO_LEN_W-1:0]    len_left;       // words left after cur_addr
word_t                      word_buf;
logic                       buf_valid;      // word_buf holds cur_addr data
logic                       stale;          // an in-flight fill belongs to the old address
sample_t                    sample_r;
logic                       advance;
logic                       fill_take;

assign advance      = enable_i && (restart_i || period_cnt == '0);
assign fill_take    = fill_i && enable_i && !restart_i && !stale;

assign fetch_req_o  = enable_i && !buf_valid;
assign fetch_addr_o = cur_addr;
assign sample_o     = sample_r;

always_ff @(posedge clk) begin
    if (fill_take) begin
        word_buf <= fill_data_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        period_cnt  <= '0;
        second_half <= 1'b0;
        cur_addr    <= '0;
        len_left    <= '0;
        buf_valid   <= 1'b0;
        stale       <= 1'b0;
        sample_r    <= '0;
        reload_o    <= 1'b0;
    end else begin
        reload_o    <= 1'b0;                // strobe

        if (!enable_i) begin
            // park at the start so enabling begins with a fetch of start_i
            period_cnt  <= period_i;
            second_half <= 1'b0;
            cur_addr    <= start_i;
            len_left    <= len_i;
            buf_valid   <= 1'b0;
            stale       <= 1'b0;
            sample_r    <= '0;
        end else begin
            if (advance) begin
                period_cnt  <= period_i;
                sample_r    <= second_half ? word_buf[7:0] : word_buf[15:8];
                second_half <= !second_half;
            end else begin
                period_cnt  <= period_cnt - 1'b1;
            end

            if (restart_i) begin
                second_half <= 1'b0;
                cur_addr    <= start_i;
                len_left    <= len_i;
                buf_valid   <= 1'b0;
                stale       <= !buf_valid && !fill_i;   // old fetch may still return
                reload_o    <= 1'b1;
            end else if (advance && second_half && buf_valid) begin
                // word used up, step to the next one
                buf_valid   <= 1'b0;
                if (len_left == '0) begin
                    cur_addr    <= start_i;
                    len_left    <= len_i;
                    reload_o    <= 1'b1;
                end else begin
                    cur_addr    <= cur_addr + 1'b1;
                    len_left    <= len_left - 1'b1;
                end
            end else if (fill_i) begin
                if (stale) begin
                    stale       <= 1'b0;            // dropped, request stays up
                end else begin
                    buf_valid   <= 1'b1;
                end
            end
        end
    end
end

endmodule

`default_nettype wire

/* src/audio_fetch_arb.sv */
// round-robin sample word fetch for all channels
// one memory request outstanding at a time; the address holds while not ready
// fill_o is combinational from the response and goes only to the granted channel

`default_nettype none
`timescale 1ns/100ps

`include "audio_config.svh"

module audio_fetch_arb (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               fetch_req_i[`AUDIO_NCHAN],
    input  wire audio_pkg::addr_t   fetch_addr_i[`AUDIO_NCHAN],
    output      logic               fill_o[`AUDIO_NCHAN],
    output      audio_pkg::word_t   fill_data_o,
    output      logic               mem_req_valid_o,
    input  wire logic               mem_req_ready_i,
    output      audio_pkg::addr_t   mem_addr_o,
    input  wire logic               mem_rsp_valid_i,
    input  wire audio_pkg::word_t   mem_rsp_data_i
);

import audio_pkg::*;

localparam int NCHAN = `AUDIO_NCHAN;
localparam int IDX_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

fetch_state_t       state;
logic [IDX_W-1:0]   grant;          // channel in service, or the last one served
addr_t              addr_r;
logic               pick_found;
logic [IDX_W-1:0]   pick_idx;

// first requester after the last grant, wrapping around
always_comb begin : pick
    int idx;
    pick_found = 1'b0;
    pick_idx   = grant;
    for (int k = 1; k <= NCHAN; k++) begin
        idx = (int'(grant) + k) % NCHAN;
        if (!pick_found && fetch_req_i[idx]) begin
            pick_found = 1'b1;
            pick_idx   = IDX_W'(idx);
        end
    end
end

always_comb begin
    for (int i = 0; i < NCHAN; i++) begin
        fill_o[i] = (state == FETCH_WAIT) && mem_rsp_valid_i && (grant == IDX_W'(i));
    end
end

assign fill_data_o     = mem_rsp_data_i;
assign mem_req_valid_o = (state == FETCH_REQ);
assign mem_addr_o      = addr_r;

always_ff @(posedge clk) begin
    if (state == FETCH_SCAN && pick_found) begin
        addr_r <= fetch_addr_i[pick_idx];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state <= FETCH_SCAN;
        grant <= IDX_W'(NCHAN - 1);         // so channel 0 is looked at first
    end else begin
        case (state)
            FETCH_SCAN: begin
                if (pick_found) begin
                    grant <= pick_idx;
                    state <= FETCH_REQ;
                end
            end
            FETCH_REQ: begin
                if (mem_req_ready_i) begin
                    state <= FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state <= FETCH_SCAN;
                end
            end
            default: state <= FETCH_SCAN;
        endcase
    end
end

endmodule

`default_nettype wire

/* src/audio_mix.sv */
// sequential left/right mixer, one channel per clock
// frame is AUDIO_NCHAN+2 clocks, outputs change once per frame
// out = sat8(sum(sample * gain7) >>> 7) + 128, 8'h80 is silence

`default_nettype none
`timescale 1ns/100ps

`include "audio_config.svh"

module audio_mix (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire audio_pkg::sample_t sample_i[`AUDIO_NCHAN],
    input  wire audio_pkg::vol_t    vol_i[`AUDIO_NCHAN],
    output      logic [7:0]         out_l_o,
    output      logic [7:0]         out_r_o
);

import audio_pkg::*;

localparam int NCHAN = `AUDIO_NCHAN;
localparam int IDX_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;
localparam int ACC_W = 16 + IDX_W;      // room for NCHAN full scale products

mix_state_t                 state;
logic [IDX_W-1:0]           chan_idx;
logic signed [ACC_W-1:0]    acc_l;
logic signed [ACC_W-1:0]    acc_r;
sample_t                    cur_sample;
logic signed [7:0]          gain_l;     // 7-bit gain, never negative
logic signed [7:0]          gain_r;
logic signed [15:0]         prod_l;
logic signed [15:0]         prod_r;

// scale down, clip to 8 bits, offset to unsigned for the DAC
function automatic logic [7:0] to_dac(input logic signed [ACC_W-1:0] sum);
    logic signed [ACC_W-1:0] scaled;
    logic [7:0]              clipped;
    scaled = sum >>> 7;
    if (scaled > 127) begin
        clipped = 8'h7f;
    end else if (scaled < -128) begin
        clipped = 8'h80;
    end else begin
        clipped = scaled[7:0];
    end
    return {~clipped[7], clipped[6:0]};
endfunction

assign cur_sample = sample_i[chan_idx];
assign gain_l     = {1'b0, vol_i[chan_idx][15:9]};
assign gain_r     = {1'b0, vol_i[chan_idx][7:1]};
assign prod_l     = cur_sample * gain_l;
assign prod_r     = cur_sample * gain_r;

always_ff @(posedge clk) begin
    if (state == MIX_CLEAR) begin
        acc_l <= '0;
        acc_r <= '0;
    end else if (state == MIX_ACC) begin
        acc_l <= acc_l + ACC_W'(prod_l);    // sign extended
        acc_r <= acc_r + ACC_W'(prod_r);
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state    <= MIX_CLEAR;
        chan_idx <= '0;
        out_l_o  <= 8'h80;
        out_r_o  <= 8'h80;
    end else begin
        case (state)
            MIX_CLEAR: begin
                chan_idx <= '0;
                state    <= MIX_ACC;
            end
            MIX_ACC: begin
                if (chan_idx == IDX_W'(NCHAN - 1)) begin
                    state    <= MIX_OUT;
                end else begin
                    chan_idx <= chan_idx + 1'b1;
                end
            end
            MIX_OUT: begin
                out_l_o <= to_dac(acc_l);
                out_r_o <= to_dac(acc_r);
                state   <= MIX_CLEAR;
            end
            default: state <= MIX_CLEAR;
        endcase
    end
end

endmodule

`default_nettype wire

/* src/audio_pdm_dac.sv */
// first-order pulse-density modulator for an 8-bit unsigned value
// output is high value_i times in any 256 clocks of a steady input

`default_nettype none
`timescale 1ns/100ps

module audio_pdm_dac (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] value_i,
    output      logic       pulse_o
);

logic [7:0] acc;        // error accumulator

always_ff @(posedge clk) begin
    if (reset_i) begin
        acc     <= '0;
        pulse_o <= 1'b0;
    end else begin
        {pulse_o, acc} <= {1'b0, acc} + {1'b0, value_i};    // carry out is the pulse
    end
end

endmodule

`default_nettype wire

/* src/audio_pkg.sv */
// shared types for the sample audio subsystem
// word_t holds two signed samples, the high byte plays first
// vol_t upper byte is left volume, lower byte right, top 7 bits used as gain

`include "audio_config.svh"

package audio_pkg;

typedef logic [`AUDIO_ADDR_W-1:0]   addr_t;     // sample memory word address
typedef logic [15:0]                word_t;     // two packed samples
typedef logic signed [7:0]          sample_t;   // one signed sample
typedef logic [15:0]                vol_t;      // {left, right} volume

// fetch arbiter states
typedef enum logic [1:0] {
    FETCH_SCAN  = 2'h0,     // pick next requesting channel
    FETCH_REQ   = 2'h1,     // memory request pending
    FETCH_WAIT  = 2'h2      // waiting for response
} fetch_state_t;

// mixer frame states
typedef enum logic [1:0] {
    MIX_CLEAR   = 2'h0,
    MIX_ACC     = 2'h1,
    MIX_OUT     = 2'h2
} mix_state_t;

endpackage

/* src/audio_subsys_top.sv */
// sample audio subsystem top: channels, fetch arbiter, mixer and two PDM DACs
// channel controls are plain inputs, there is no register interface
// irq_o is one clock after any reload strobe

`default_nettype none
`timescale 1ns/100ps

`include "audio_config.svh"

module audio_subsys_top (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       chan_enable_i[`AUDIO_NCHAN],
    input  wire audio_pkg::vol_t            chan_vol_i[`AUDIO_NCHAN],
    input  wire logic [`AUDIO_PERIOD_W-1:0] chan_period_i[`AUDIO_NCHAN],
    input  wire audio_pkg::addr_t           chan_start_i[`AUDIO_NCHAN],
    input  wire logic [`AUDIO_LEN_W-1:0]    chan_len_i[`AUDIO_NCHAN],
    input  wire logic                       chan_restart_i[`AUDIO_NCHAN],
    output      logic                       reload_o[`AUDIO_NCHAN],
    output      logic                       irq_o,
    output      logic                       mem_req_valid_o,
    input  wire logic                       mem_req_ready_i,
    output      audio_pkg::addr_t           mem_addr_o,
    input  wire logic                       mem_rsp_valid_i,
    input  wire audio_pkg::word_t           mem_rsp_data_i,
    output      logic                       pdm_l_o,
    output      logic                       pdm_r_o
);

import audio_pkg::*;

logic       fetch_req[`AUDIO_NCHAN];
addr_t      fetch_addr[`AUDIO_NCHAN];
logic       fill[`AUDIO_NCHAN];
word_t      fill_data;
sample_t    chan_sample[`AUDIO_NCHAN];
logic [7:0] mix_l;
logic [7:0] mix_r;
logic       reload_any;

for (genvar i = 0; i < `AUDIO_NCHAN; i++) begin : g_chan
    audio_channel i_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .enable_i    (chan_enable_i[i]),
        .vol_i       (chan_vol_i[i]),
        .period_i    (chan_period_i[i]),
        .start_i     (chan_start_i[i]),
        .len_i       (chan_len_i[i]),
        .restart_i   (chan_restart_i[i]),
        .fetch_req_o (fetch_req[i]),
        .fetch_addr_o(fetch_addr[i]),
        .fill_i      (fill[i]),
        .fill_data_i (fill_data),
        .sample_o    (chan_sample[i]),
        .reload_o    (reload_o[i])
    );
end

audio_fetch_arb i_arb (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fill_o         (fill),
    .fill_data_o    (fill_data),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_addr_o     (mem_addr_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_data_i (mem_rsp_data_i)
);

// volume goes straight to the mixer
audio_mix i_mix (
    .clk     (clk),
    .reset_i (reset_i),
    .sample_i(chan_sample),
    .vol_i   (chan_vol_i),
    .out_l_o (mix_l),
    .out_r_o (mix_r)
);

audio_pdm_dac i_dac_l (
    .clk    (clk),
    .reset_i(reset_i),
    .value_i(mix_l),
    .pulse_o(pdm_l_o)
);

audio_pdm_dac i_dac_r (
    .clk    (clk),
    .reset_i(reset_i),
    .value_i(mix_r),
    .pulse_o(pdm_r_o)
);

always_comb begin
    reload_any = 1'b0;
    for (int i = 0; i < `AUDIO_NCHAN; i++) begin
        reload_any = reload_any | reload_o[i];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        irq_o <= 1'b0;
    end else begin
        irq_o <= reload_any;
    end
end

endmodule

`default_nettype wire
